// File: logic/aes_pkg.sv
//------------------------------------------------
// AES encipher shared definitions
// Block and word types, the state register update
// commands, controller states and GF(2^8) helpers
//------------------------------------------------

package aes_pkg;

  //------------------------------------------------
  // Data types
  //------------------------------------------------

  // One state column, row 0 in the top byte
  typedef logic [31:0] word_t;

  // Full 128-bit block, column w0 in the top word
  typedef struct packed {
    word_t w0;
    word_t w1;
    word_t w2;
    word_t w3;
  } block_t;

  // Round key index requested from the key source
  typedef logic [3:0] round_idx_t;

  // Column currently passing through the S-box
  typedef logic [1:0] word_sel_t;

  //------------------------------------------------
  // Control encodings
  //------------------------------------------------

  // State register update operations
  typedef enum logic [2:0] {
    UPD_NONE,
    UPD_INIT,
    UPD_SBOX,
    UPD_MAIN,
    UPD_FINAL
  } update_e;

  // Sequencing FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INIT,
    ST_SBOX,
    ST_ROUND,
    ST_DONE
  } ctrl_state_e;

  // Command from the controller to the state register
  typedef struct packed {
    update_e   op;
    word_sel_t sel;
  } upd_cmd_t;

  // Round count for a 128-bit key
  localparam int AES128_ROUNDS = 10;

  //------------------------------------------------
  // GF(2^8) arithmetic
  //------------------------------------------------

  // Multiply by x, reducing with x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_double(input logic [7:0] b);
    logic [7:0] shl;
    shl = {b[6:0], 1'b0};
    if (b[7])
      gf_double = shl ^ 8'h1b;
    else
      gf_double = shl;
  endfunction

endpackage

// File: logic/aes_sbox.sv
//------------------------------------------------
// AES forward S-box
// Substitutes all four bytes of one state word
//------------------------------------------------

`timescale 1ns/100ps

module aes_sbox (
  input  aes_pkg::word_t in_word,
  output aes_pkg::word_t out_word
);

  // Forward substitution table, indexed by the input byte
  localparam logic [7:0] SBOX_TABLE [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Four independent byte lookups in parallel
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      out_word[8*i +: 8] = SBOX_TABLE[in_word[8*i +: 8]];
    end
  end

endmodule

// File: logic/aes_shift_mix.sv
//------------------------------------------------
// AES ShiftRows and MixColumns
// Gives the row-shifted block and its mixed form
//------------------------------------------------

`timescale 1ns/100ps

module aes_shift_mix (
  input  aes_pkg::block_t state,
  output aes_pkg::block_t shifted,
  output aes_pkg::block_t mixed
);

  import aes_pkg::*;

  // Column views of the input and both results
  word_t in_col [4];
  word_t sh_col [4];
  word_t mx_col [4];

  // Mix one column, row 0 in the top byte
  function automatic word_t mix_column(input word_t col);
    logic [7:0] a  [4];
    logic [7:0] a2 [4];
    logic [7:0] a3 [4];
    for (int r = 0; r < 4; r++)
    begin
      a[r]  = col[31-8*r -: 8];
      a2[r] = gf_double(a[r]);
      // Times 3 is times 2 plus the byte itself
      a3[r] = a2[r] ^ a[r];
    end
    mix_column[31:24] = a2[0] ^ a3[1] ^ a[2]  ^ a[3];
    mix_column[23:16] = a[0]  ^ a2[1] ^ a3[2] ^ a[3];
    mix_column[15:8]  = a[0]  ^ a[1]  ^ a2[2] ^ a3[3];
    mix_column[7:0]   = a3[0] ^ a[1]  ^ a[2]  ^ a2[3];
  endfunction

  always_comb
  begin
    in_col[0] = state.w0;
    in_col[1] = state.w1;
    in_col[2] = state.w2;
    in_col[3] = state.w3;
    // Row r rotates left by r columns
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        sh_col[c][31-8*r -: 8] = in_col[(c + r) % 4][31-8*r -: 8];
      end
      mx_col[c] = mix_column(sh_col[c]);
    end
  end

  assign shifted = '{w0: sh_col[0], w1: sh_col[1], w2: sh_col[2], w3: sh_col[3]};
  assign mixed   = '{w0: mx_col[0], w1: mx_col[1], w2: mx_col[2], w3: mx_col[3]};

endmodule

// File: logic/aes_state_reg.sv
//------------------------------------------------
// AES state register
// Holds the four state columns and applies the
// commanded update, including AddRoundKey
//------------------------------------------------

`timescale 1ns/100ps

module aes_state_reg (
  input  logic              clk,
  input  logic              reset_n,
  input  aes_pkg::upd_cmd_t cmd,
  input  aes_pkg::block_t   block,
  input  aes_pkg::block_t   round_key,
  input  aes_pkg::block_t   shifted,
  input  aes_pkg::block_t   mixed,
  input  aes_pkg::word_t    sub_word,
  output aes_pkg::word_t    sbox_word,
  output aes_pkg::block_t   state
);

  import aes_pkg::*;

  //------------------------------------------------
  // S-box input select
  //------------------------------------------------

  // Column picked by the word counter goes to the S-box
  always_comb
  begin
    case (cmd.sel)
      2'd0:    sbox_word = state.w0;
      2'd1:    sbox_word = state.w1;
      2'd2:    sbox_word = state.w2;
      default: sbox_word = state.w3;
    endcase
  end

  //------------------------------------------------
  // State update
  //------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= '0;
    end
    else
    begin
      case (cmd.op)
        // Initial AddRoundKey on the plaintext
        UPD_INIT:
          state <= block_t'(block ^ round_key);
        // Only the selected column takes the substituted word
        UPD_SBOX:
        begin
          case (cmd.sel)
            2'd0:    state.w0 <= sub_word;
            2'd1:    state.w1 <= sub_word;
            2'd2:    state.w2 <= sub_word;
            default: state.w3 <= sub_word;
          endcase
        end
        // Main round closes with MixColumns then AddRoundKey
        UPD_MAIN:
          state <= block_t'(mixed ^ round_key);
        // Last round skips MixColumns
        UPD_FINAL:
          state <= block_t'(shifted ^ round_key);
        default:
          state <= state;
      endcase
    end
  end

  // Controller never issues an undefined or unknown update
  a_cmd_legal: assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown(cmd.op) && (cmd.op inside {UPD_NONE, UPD_INIT, UPD_SBOX, UPD_MAIN, UPD_FINAL}))
    else $error("aes_state_reg: illegal update op %0d", cmd.op);

endmodule

// File: logic/aes_round_ctrl.sv
//------------------------------------------------
// AES round controller
// Sequences init, SubBytes words and rounds, and
// runs the four-phase req/ack start handshake
//------------------------------------------------

`timescale 1ns/100ps

module aes_round_ctrl #(
  parameter int NUM_ROUNDS = aes_pkg::AES128_ROUNDS
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                req,
  output logic                ack,
  output logic                busy,
  output aes_pkg::round_idx_t round,
  output aes_pkg::upd_cmd_t   cmd
);

  import aes_pkg::*;

  // Index of the round without MixColumns
  localparam round_idx_t LAST_ROUND = round_idx_t'(NUM_ROUNDS);

  ctrl_state_e state_reg;
  ctrl_state_e state_next;
  round_idx_t  round_reg;
  round_idx_t  round_next;
  word_sel_t   word_reg;
  word_sel_t   word_next;
  logic        ack_reg;
  logic        ack_next;
  logic        last_round;

  assign last_round = (round_reg == LAST_ROUND);

  //------------------------------------------------
  // Registers
  //------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= ST_IDLE;
      round_reg <= '0;
      word_reg  <= '0;
      ack_reg   <= 1'b0;
    end
    else
    begin
      state_reg <= state_next;
      round_reg <= round_next;
      word_reg  <= word_next;
      ack_reg   <= ack_next;
    end
  end

  //------------------------------------------------
  // Sequencing FSM
  //------------------------------------------------

  always_comb
  begin
    state_next = state_reg;
    round_next = round_reg;
    word_next  = word_reg;
    ack_next   = ack_reg;
    case (state_reg)
      ST_IDLE:
      begin
        // Key 0 is requested during the init cycle
        if (req)
        begin
          round_next = '0;
          state_next = ST_INIT;
        end
      end
      ST_INIT:
      begin
        word_next  = '0;
        round_next = round_reg + 1'b1;
        state_next = ST_SBOX;
      end
      ST_SBOX:
      begin
        // One column per cycle, counter wraps back to 0
        word_next = word_reg + 1'b1;
        if (word_reg == 2'd3)
          state_next = ST_ROUND;
      end
      ST_ROUND:
      begin
        if (last_round)
        begin
          state_next = ST_DONE;
        end
        else
        begin
          round_next = round_reg + 1'b1;
          state_next = ST_SBOX;
        end
      end
      ST_DONE:
      begin
        // Raise ack, then hold it until req drops
        if (!ack_reg)
        begin
          ack_next = 1'b1;
        end
        else if (!req)
        begin
          ack_next   = 1'b0;
          state_next = ST_IDLE;
        end
      end
      default:
        state_next = ST_IDLE;
    endcase
  end

  //------------------------------------------------
  // Outputs
  //------------------------------------------------

  always_comb
  begin
    cmd.sel = word_reg;
    case (state_reg)
      ST_INIT:  cmd.op = UPD_INIT;
      ST_SBOX:  cmd.op = UPD_SBOX;
      ST_ROUND: cmd.op = last_round ? UPD_FINAL : UPD_MAIN;
      default:  cmd.op = UPD_NONE;
    endcase
  end

  assign busy  = (state_reg inside {ST_INIT, ST_SBOX, ST_ROUND});
  assign ack   = ack_reg;
  assign round = round_reg;

  // Key index stays within the supplied key schedule
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
    round_reg <= LAST_ROUND)
    else $error("aes_round_ctrl: round %0d beyond %0d", round_reg, NUM_ROUNDS);

  // Result is only acknowledged once processing has stopped
  a_ack_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
    !(ack && busy))
    else $error("aes_round_ctrl: ack and busy both high");

endmodule

// File: logic/aes_encipher.sv
//------------------------------------------------
// AES block encipher engine
// Word-serial SubBytes with externally supplied
// round keys, started by a req/ack handshake
//------------------------------------------------

`timescale 1ns/100ps

module aes_encipher #(
  parameter int NUM_ROUNDS = aes_pkg::AES128_ROUNDS
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                req,
  input  aes_pkg::block_t     block,
  input  aes_pkg::block_t     round_key,
  output logic                ack,
  output logic                busy,
  output aes_pkg::round_idx_t round,
  output aes_pkg::block_t     result
);

  import aes_pkg::*;

  // Controller to state register
  upd_cmd_t cmd;

  // S-box path
  word_t sbox_word;
  word_t sub_word;

  // Round function results
  block_t shifted;
  block_t mixed;

  aes_round_ctrl #(
    .NUM_ROUNDS(NUM_ROUNDS)
  ) u_round_ctrl (
    .clk    (clk),
    .reset_n(reset_n),
    .req    (req),
    .ack    (ack),
    .busy   (busy),
    .round  (round),
    .cmd    (cmd)
  );

  // The state register output is the ciphertext
  aes_state_reg u_state_reg (
    .clk      (clk),
    .reset_n  (reset_n),
    .cmd      (cmd),
    .block    (block),
    .round_key(round_key),
    .shifted  (shifted),
    .mixed    (mixed),
    .sub_word (sub_word),
    .sbox_word(sbox_word),
    .state    (result)
  );

  aes_sbox u_sbox (
    .in_word (sbox_word),
    .out_word(sub_word)
  );

  aes_shift_mix u_shift_mix (
    .state  (result),
    .shifted(shifted),
    .mixed  (mixed)
  );

endmodule

// File: testbench/tb_aes_vectors.svh
//------------------------------------------------
// FIPS-197 AES-128 reference vectors
// Appendix C.1 and Appendix B plaintexts, results
// and full round key schedules, key 0 first
//------------------------------------------------

`ifndef TB_AES_VECTORS_SVH
`define TB_AES_VECTORS_SVH

// Highest key index in an AES-128 schedule
localparam int KEY_LAST = 10;

// Appendix C.1, key 000102...0f
localparam block_t C1_PLAIN  = 128'h00112233445566778899aabbccddeeff;
localparam block_t C1_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam logic [11*128-1:0] C1_KEYS = {
  128'h000102030405060708090a0b0c0d0e0f,
  128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
  128'hb692cf0b643dbdf1be9bc5006830b3fe,
  128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
  128'h47f7f7bc95353e03f96c32bcfd058dfd,
  128'h3caaa3e8a99f9deb50f3af57adf622aa,
  128'h5e390f7df7a69296a7553dc10aa31f6b,
  128'h14f9701ae35fe28c440adf4d4ea9c026,
  128'h47438735a41c65b9e016baf4aebf7ad2,
  128'h549932d1f08557681093ed9cbe2c974e,
  128'h13111d7fe3944a17f307a78b4d2b30c5
};

// Appendix B, key 2b7e1516...
localparam block_t B_PLAIN  = 128'h3243f6a8885a308d313198a2e0370734;
localparam block_t B_CIPHER = 128'h3925841d02dc09fbdc118597196a0b32;
localparam logic [11*128-1:0] B_KEYS = {
  128'h2b7e151628aed2a6abf7158809cf4f3c,
  128'ha0fafe1788542cb123a339392a6c7605,
  128'hf2c295f27a96b9435935807a7359f67f,
  128'h3d80477d4716fe3e1e237e446d7a883b,
  128'hef44a541a8525b7fb671253bdb0bad00,
  128'hd4d1c6f87c839d87caf2b8bc11f915bc,
  128'h6d88a37a110b3efddbf98641ca0093fd,
  128'h4e54f70e5f5fc9f384a64fb24ea6dc4f,
  128'head27321b58dbad2312bf5607f8d292f,
  128'hac7766f319fadc2128d12941575c006e,
  128'hd014f9a8c9ee2589e13f0cc8b6630ca6
};

`endif

// File: testbench/tb_aes_encipher.sv
//------------------------------------------------
// AES encipher engine testbench
// Runs the FIPS-197 vectors through the req/ack
// handshake and checks timing and key requests
//------------------------------------------------

`timescale 1ns/100ps

module tb_aes_encipher;

  import aes_pkg::*;

  `include "tb_aes_vectors.svh"

  localparam int NUM_ROUNDS = AES128_ROUNDS;
  // Last busy cycle and the ack cycle counted from edge 0
  localparam int BUSY_LAST = 5 * NUM_ROUNDS;
  localparam int ACK_EDGE  = 5 * NUM_ROUNDS + 2;
  // Four operations of about 60 cycles plus margin
  localparam int OP_BUDGET      = 100;
  localparam int TIMEOUT_CYCLES = 4 * OP_BUDGET;

  logic       clk;
  logic       reset_n;
  logic       req;
  logic       ack;
  logic       busy;
  logic       use_vec_b;
  round_idx_t round;
  block_t     block;
  block_t     round_key;
  block_t     result;
  int         seed = 32'h3f784b4c;
  int         cycle_count = 0;
  int         error_count = 0;

  aes_encipher #(
    .NUM_ROUNDS(NUM_ROUNDS)
  ) DUT (
    .clk      (clk),
    .reset_n  (reset_n),
    .req      (req),
    .block    (block),
    .round_key(round_key),
    .ack      (ack),
    .busy     (busy),
    .round    (round),
    .result   (result)
  );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  // Key source answers the requested index in the same cycle
  always_comb
  begin
    if (round > KEY_LAST)
      round_key = '0;
    else if (use_vec_b)
      round_key = B_KEYS[128*(KEY_LAST - round) +: 128];
    else
      round_key = C1_KEYS[128*(KEY_LAST - round) +: 128];
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped by watchdog");
    end
  end

  //------------------------------------------------
  // Compare tasks
  //------------------------------------------------

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_block(input string what, input block_t got, input block_t exp);
    if (got !== exp)
      report_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_round(input string what, input round_idx_t got,
                             input round_idx_t exp);
    if (got !== exp)
      report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  //------------------------------------------------
  // Directed tests
  //------------------------------------------------

  // Outputs right after reset release
  task automatic verify_reset();
    @(negedge clk);
    check_bit("ack after reset", ack, 1'b0);
    check_bit("busy after reset", busy, 1'b0);
    check_round("round after reset", round, '0);
    check_block("result after reset", result, '0);
  endtask

  // One full operation followed by req held for some cycles
  task automatic encipher_vector(input logic vec_b, input int hold);
    block_t     cipher;
    round_idx_t prev_round;
    logic       ack_seen;
    int         edge_idx;
    int         i;
    cipher    = vec_b ? B_CIPHER : C1_CIPHER;
    use_vec_b = vec_b;
    block     = vec_b ? B_PLAIN : C1_PLAIN;
    req       = 1'b1;
    edge_idx   = 0;
    prev_round = '0;
    ack_seen   = 1'b0;
    // Edge 0 is the next rising edge
    while (!ack_seen)
    begin
      @(negedge clk);
      check_bit("busy", busy, edge_idx <= BUSY_LAST);
      check_bit("ack", ack, edge_idx == ACK_EDGE);
      if (edge_idx == 0)
        check_round("first key index", round, '0);
      if (edge_idx <= BUSY_LAST)
      begin
        if (round < prev_round)
          report_error($sformatf("round index fell from %0d to %0d", prev_round, round));
        if (round > NUM_ROUNDS)
          report_error($sformatf("round index %0d beyond %0d", round, NUM_ROUNDS));
        prev_round = round;
      end
      ack_seen = ack;
      edge_idx++;
    end
    check_round("last key index", prev_round, round_idx_t'(NUM_ROUNDS));
    check_block("ciphertext", result, cipher);
    // Back-pressure keeps ack and the result
    for (i = 0; i < hold; i++)
    begin
      @(negedge clk);
      check_bit("ack while req held", ack, 1'b1);
      check_bit("busy while req held", busy, 1'b0);
      check_block("ciphertext while req held", result, cipher);
    end
    req = 1'b0;
    @(negedge clk);
    check_bit("ack after req low", ack, 1'b0);
    check_block("ciphertext after handshake", result, cipher);
  endtask

  // Block changes while idle must not reach the state
  task automatic idle_block_change(input int gap, input block_t held);
    int i;
    for (i = 0; i < gap; i++)
    begin
      block = block_t'({$random(seed), $random(seed), $random(seed), $random(seed)});
      @(negedge clk);
      check_block("result while idle", result, held);
      check_bit("ack while idle", ack, 1'b0);
      check_bit("busy while idle", busy, 1'b0);
    end
  endtask

  //------------------------------------------------
  // Test sequence
  //------------------------------------------------

  initial
  begin
    int hold;
    int gap;
    reset_n   = 1'b0;
    req       = 1'b0;
    block     = '0;
    use_vec_b = 1'b0;
    repeat (4) @(negedge clk);
    reset_n = 1'b1;
    verify_reset();
    hold = $unsigned($random(seed)) % 6 + 1;
    encipher_vector(1'b0, hold);
    gap = $unsigned($random(seed)) % 6 + 2;
    idle_block_change(gap, C1_CIPHER);
    hold = $unsigned($random(seed)) % 6 + 1;
    encipher_vector(1'b1, hold);
    // Back-to-back operations with a new req as soon as ack is low
    encipher_vector(1'b0, 0);
    encipher_vector(1'b1, 0);
    if (error_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: aes_encipher.f
+incdir+testbench
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/aes_shift_mix.sv
logic/aes_state_reg.sv
logic/aes_round_ctrl.sv
logic/aes_encipher.sv
testbench/tb_aes_encipher.sv
